//--- mem_sys.f
hdl/mem_sys_pkg.sv
hdl/cache_way.sv
hdl/cache_ctrl.sv
hdl/banked_mem.sv
hdl/mem_system.sv
test/mem_checker.sv
test/tb_mem_system.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the cache system testbench with Verilator
cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary -j 0 --top-module tb_mem_system -f mem_sys.f -o tb_mem_system
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/tb_mem_system > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -q "Done: errors found" "$log"; then
   exit 1
fi
exit 0

//--- test/mem_golden.txt
# op addr wdata rdata hit   op: R read, W write, B read and write together
# rdata is the expected read data (reads only), hit the expected cache_hit flag
W 0008 a5a5 0000 0
R 0008 0000 a5a5 1
W 000a 1234 0000 1
R 000a 0000 1234 1
R 0100 0000 0000 0
R 0106 0000 0000 1
R 0102 0000 0000 1
W 0010 1111 0000 0
W 0812 2222 0000 0
W 1014 3333 0000 0
R 0010 0000 1111 0
R 0812 0000 2222 0
R 1014 0000 3333 0
W 0018 aaaa 0000 0
W 0818 bbbb 0000 0
R 0018 0000 aaaa 1
W 1018 cccc 0000 0
R 0018 0000 aaaa 1
R 0818 0000 bbbb 0
R 1018 0000 cccc 0
B 0008 ffff 0000 0
R 0009 0000 0000 0
W 000b 5555 0000 0
R 0008 0000 a5a5 1
R 000a 0000 1234 1
R 1018 0000 cccc 1
R 0818 0000 bbbb 1

//--- test/tb_mem_system.sv
`timescale 1ns/1ps
// Testbench top for the cache system: clock, reset, golden-file stimulus,
// random idle gaps and a cycle-limit timeout
module tb_mem_system;

   logic                           clk;
   logic                           rst_n;
   logic [mem_sys_pkg::ADDR_W-1:0] addr;
   logic [mem_sys_pkg::DATA_W-1:0] data_in;
   logic                           rd;
   logic                           wr;
   logic [mem_sys_pkg::DATA_W-1:0] data_out;
   logic                           done;
   logic                           stall;
   logic                           cache_hit;
   logic                           err;
   logic [mem_sys_pkg::DATA_W-1:0] exp_rdata;
   logic                           exp_hit;
   logic                           report;
   logic                           load_ok;
   int                             error_count;
   int                             cycle_count = 0;
   int                             cycle_limit = 0;

   logic [7:0]                     op_q    [$];
   logic [mem_sys_pkg::ADDR_W-1:0] addr_q  [$];
   logic [mem_sys_pkg::DATA_W-1:0] wdata_q [$];
   logic [mem_sys_pkg::DATA_W-1:0] rdata_q [$];
   logic                           hit_q   [$];

   mem_system dut (
      .clk, .rst_n, .addr, .data_in, .rd, .wr,
      .data_out, .done, .stall, .cache_hit, .err
   );

   mem_checker checker_u (
      .clk, .rst_n, .addr, .data_in, .rd, .wr,
      .data_out, .done, .stall, .cache_hit, .err,
      .exp_rdata, .exp_hit, .report, .error_count
   );

   always #10 clk = ~clk;

   always @(posedge clk) begin
      cycle_count <= cycle_count + 1;
      if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
         $display("Timeout: run still busy after %0d cycles", cycle_count);
         $display("Done: errors found");
         $finish;
      end
   end

   task automatic load_golden(output logic ok);
      int          fd;
      int          fields;
      string       line;
      logic [7:0]  op;
      logic [15:0] a;
      logic [15:0] d;
      logic [15:0] r;
      logic [3:0]  h;
      ok = 1'b1;
      fd = $fopen("test/mem_golden.txt", "r");
      if (fd == 0) begin
         $display("Cannot open the golden file test/mem_golden.txt");
         ok = 1'b0;
      end else begin
         while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() > 1 && line.getc(0) != "#") begin
               fields = $sscanf(line, "%c %h %h %h %h", op, a, d, r, h);
               if (fields != 5 || h > 1 || !(op == "R" || op == "W" || op == "B")) begin
                  $display("Malformed golden line: %s", line);
                  ok = 1'b0;
               end else begin
                  op_q.push_back(op);
                  addr_q.push_back(a);
                  wdata_q.push_back(d);
                  rdata_q.push_back(r);
                  hit_q.push_back(h[0]);
               end
            end
         end
         $fclose(fd);
         if (op_q.size() == 0) begin
            $display("The golden file holds no requests");
            ok = 1'b0;
         end
      end
   endtask

   // One request held until done, then 0 to 3 idle cycles
   task automatic run_request(input int i);
      int idle;
      @(posedge clk);
      addr      <= addr_q[i];
      data_in   <= wdata_q[i];
      rd        <= (op_q[i] != "W");
      wr        <= (op_q[i] != "R");
      exp_rdata <= rdata_q[i];
      exp_hit   <= hit_q[i];
      @(posedge clk);
      while (!done) @(posedge clk);
      rd   <= 1'b0;
      wr   <= 1'b0;
      idle = $urandom % 4;
      repeat (idle) @(posedge clk);
   endtask

   initial begin
      clk       = 1'b0;
      rst_n     = 1'b0;
      addr      = '0;
      data_in   = '0;
      rd        = 1'b0;
      wr        = 1'b0;
      exp_rdata = '0;
      exp_hit   = 1'b0;
      report    = 1'b0;
      void'($urandom(32'ha22e_e9c1));
      load_golden(load_ok);
      if (!load_ok) begin
         $display("Done: errors found");
         $finish;
      end else begin
         cycle_limit = 20 * op_q.size() + 100;
         repeat (2) @(posedge clk);
         rst_n <= 1'b1;
         for (int i = 0; i < op_q.size(); i++) begin
            run_request(i);
         end
         @(posedge clk);
         report = 1'b1;
         #1;
         if (error_count == 0) begin
            $display("Done: no errors");
         end else begin
            $display("Done: errors found");
         end
         $finish;
      end
   end

endmodule

//--- test/mem_checker.sv
`timescale 1ns/1ps
// Response checker with a reference word memory
// Compares read data, hit and error flags, stall and done timing of each request
module mem_checker (
   input  logic                           clk,
   input  logic                           rst_n,
   input  logic [mem_sys_pkg::ADDR_W-1:0] addr,
   input  logic [mem_sys_pkg::DATA_W-1:0] data_in,
   input  logic                           rd,
   input  logic                           wr,
   input  logic [mem_sys_pkg::DATA_W-1:0] data_out,
   input  logic                           done,
   input  logic                           stall,
   input  logic                           cache_hit,
   input  logic                           err,
   input  logic [mem_sys_pkg::DATA_W-1:0] exp_rdata,
   input  logic                           exp_hit,
   input  logic                           report,
   output int                             error_count
);

   logic [mem_sys_pkg::DATA_W-1:0] ref_mem [mem_sys_pkg::MEM_WORDS] = '{default: '0};
   logic busy = 1'b0;
   int   cycles = 0;
   int   errors = 0;
   int   request_count = 0;

   assign error_count = errors;

   task automatic compare_hex(input string name, input logic [15:0] expected,
                              input logic [15:0] actual);
      if (expected !== actual) begin
         $display("Error %s expected %h got %h", name, expected, actual);
         errors++;
      end
   endtask

   task automatic check_response();
      logic exp_err;
      exp_err = (rd && wr) || addr[0];
      request_count++;
      compare_hex("err", 16'(exp_err), 16'(err));
      compare_hex("cache_hit", 16'(exp_hit), 16'(cache_hit));
      if (exp_err) begin
         if (cycles != 1) begin
            $display("Bad request at %h took %0d cycles instead of 1", addr, cycles);
            errors++;
         end
      end else begin
         if (exp_hit && cycles != 2) begin
            $display("Hit at %h finished %0d cycles after acceptance instead of 2",
                     addr, cycles);
            errors++;
         end
         if (rd) begin
            compare_hex("data_out", ref_mem[addr[mem_sys_pkg::ADDR_W-1:1]], data_out);
            compare_hex("data_out", exp_rdata, data_out);
         end else begin
            ref_mem[addr[mem_sys_pkg::ADDR_W-1:1]] = data_in;
         end
      end
   endtask

   always @(posedge clk) begin
      if (!rst_n) begin
         busy   = 1'b0;
         cycles = 0;
      end else if (busy) begin
         cycles++;
         if (!stall) begin
            $display("Stall went low %0d cycles into the request at %h", cycles, addr);
            errors++;
         end
         if (done) begin
            check_response();
            busy = 1'b0;
         end
      end else begin
         if (done) begin
            $display("Done came with no request outstanding");
            errors++;
         end
         // Acceptance edge
         if ((rd || wr) && !stall) begin
            busy   = 1'b1;
            cycles = 0;
         end
      end
   end

   always @(posedge report) begin
      $display("Checked %0d requests, %0d errors", request_count, errors);
   end

endmodule

//--- hdl/mem_system.sv
`timescale 1ns/1ps
// Top level of the two-way cache and banked memory
module mem_system (
   input  logic                           clk,
   input  logic                           rst_n,
   input  logic [mem_sys_pkg::ADDR_W-1:0] addr,
   input  logic [mem_sys_pkg::DATA_W-1:0] data_in,
   input  logic                           rd,
   input  logic                           wr,
   output logic [mem_sys_pkg::DATA_W-1:0] data_out,
   output logic                           done,
   output logic                           stall,
   output logic                           cache_hit,
   output logic                           err
);

   logic [mem_sys_pkg::DATA_W-1:0] way_wdata, mem_wdata, mem_rdata;
   logic [mem_sys_pkg::DATA_W-1:0] rdata0, rdata1;
   logic [mem_sys_pkg::TAG_W-1:0]  tag0, tag1, mem_tag, req_tag;
   logic [mem_sys_pkg::INDEX_W-1:0] index;
   logic [mem_sys_pkg::OFF_W-1:0]  way_offset, mem_offset;
   logic [1:0] way_en, way_hit, way_valid, way_dirty;
   logic way_comp, way_write, fill_src, tag_src, mem_rd, mem_wr;

   assign req_tag = addr[mem_sys_pkg::ADDR_W-1 -: mem_sys_pkg::TAG_W];
   assign index   = addr[mem_sys_pkg::OFF_W+1 +: mem_sys_pkg::INDEX_W];

   cache_ctrl ctrl (
      .clk, .rst_n, .addr, .rd, .wr,
      .way_hit, .way_valid, .way_dirty,
      .way_en, .way_offset, .way_comp, .way_write,
      .fill_src, .tag_src,
      .mem_rd, .mem_wr, .mem_offset,
      .done, .stall, .cache_hit, .err
   );

   cache_way way0 (
      .clk, .rst_n, .en(way_en[0]), .comp(way_comp), .write(way_write),
      .tag_in(req_tag), .index, .offset(way_offset), .wdata(way_wdata),
      .rdata(rdata0), .tag_out(tag0), .hit(way_hit[0]),
      .valid(way_valid[0]), .dirty(way_dirty[0])
   );

   cache_way way1 (
      .clk, .rst_n, .en(way_en[1]), .comp(way_comp), .write(way_write),
      .tag_in(req_tag), .index, .offset(way_offset), .wdata(way_wdata),
      .rdata(rdata1), .tag_out(tag1), .hit(way_hit[1]),
      .valid(way_valid[1]), .dirty(way_dirty[1])
   );

   banked_mem mem (
      .clk, .rst_n,
      .addr({mem_tag, index, mem_offset, 1'b0}),
      .wdata(mem_wdata), .rd(mem_rd), .wr(mem_wr), .rdata(mem_rdata)
   );

   // Request data on hits, memory data during a fill
   assign way_wdata = fill_src ? data_in : mem_rdata;

   // Victim tag addresses the write-back, request tag the fill
   assign mem_tag   = tag_src ? req_tag : (way_en[0] ? tag0 : tag1);
   assign mem_wdata = way_en[0] ? rdata0 : rdata1;

   assign data_out  = (way_en[0] && way_hit[0]) ? rdata0 : rdata1;

endmodule

//--- hdl/banked_mem.sv
`timescale 1ns/1ps
// Four word-interleaved memory banks
// Fixed read latency with a pipelined read path
module banked_mem (
   input  logic                           clk,
   input  logic                           rst_n,
   input  logic [mem_sys_pkg::ADDR_W-1:0] addr,
   input  logic [mem_sys_pkg::DATA_W-1:0] wdata,
   input  logic                           rd,
   input  logic                           wr,
   output logic [mem_sys_pkg::DATA_W-1:0] rdata
);

   logic [mem_sys_pkg::DATA_W-1:0] bank_mem
      [mem_sys_pkg::LINE_WORDS][mem_sys_pkg::BANK_ROWS] = '{default: '0};

   logic [mem_sys_pkg::OFF_W-1:0] bank_sel;
   logic [mem_sys_pkg::ROW_W-1:0] row;

   // Bank and row of each read in flight
   logic [mem_sys_pkg::MEM_LAT-1:0] pipe_vld;
   logic [mem_sys_pkg::OFF_W-1:0]   pipe_bank [mem_sys_pkg::MEM_LAT];
   logic [mem_sys_pkg::ROW_W-1:0]   pipe_row  [mem_sys_pkg::MEM_LAT];

   assign bank_sel = addr[1 +: mem_sys_pkg::OFF_W];
   assign row      = addr[mem_sys_pkg::ADDR_W-1 -: mem_sys_pkg::ROW_W];

   always_ff @(posedge clk) begin
      if (wr) begin
         bank_mem[bank_sel][row] <= wdata;
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         pipe_vld <= '0;
      end else begin
         pipe_vld[0] <= rd;
         for (int k = 1; k < mem_sys_pkg::MEM_LAT; k++) begin
            pipe_vld[k] <= pipe_vld[k-1];
         end
      end
   end

   always_ff @(posedge clk) begin
      pipe_bank[0] <= bank_sel;
      pipe_row[0]  <= row;
      for (int k = 1; k < mem_sys_pkg::MEM_LAT; k++) begin
         pipe_bank[k] <= pipe_bank[k-1];
         pipe_row[k]  <= pipe_row[k-1];
      end
   end

   // Last stage reads the bank, so data shows MEM_LAT edges after issue
   always_ff @(posedge clk) begin
      if (pipe_vld[mem_sys_pkg::MEM_LAT-1]) begin
         rdata <= bank_mem[pipe_bank[mem_sys_pkg::MEM_LAT-1]]
                          [pipe_row[mem_sys_pkg::MEM_LAT-1]];
      end
   end

endmodule

//--- hdl/cache_ctrl.sv
`timescale 1ns/1ps
// Cache controller FSM: request capture, hit/miss decision, LRU victim,
// write-back of dirty lines and pipelined line fill
module cache_ctrl (
   input  logic                           clk,
   input  logic                           rst_n,
   input  logic [mem_sys_pkg::ADDR_W-1:0] addr,
   input  logic                           rd,
   input  logic                           wr,
   input  logic [1:0]                     way_hit,
   input  logic [1:0]                     way_valid,
   input  logic [1:0]                     way_dirty,
   output logic [1:0]                     way_en,
   output logic [mem_sys_pkg::OFF_W-1:0]  way_offset,
   output logic                           way_comp,
   output logic                           way_write,
   output logic                           fill_src,
   output logic                           tag_src,
   output logic                           mem_rd,
   output logic                           mem_wr,
   output logic [mem_sys_pkg::OFF_W-1:0]  mem_offset,
   output logic                           done,
   output logic                           stall,
   output logic                           cache_hit,
   output logic                           err
);

   mem_sys_pkg::ctrl_state_t state;
   mem_sys_pkg::ctrl_state_t state_nxt;

   logic [mem_sys_pkg::INDEX_W-1:0]  index;
   logic [mem_sys_pkg::OFF_W-1:0]    req_offset;
   logic                             bad_req;
   logic [mem_sys_pkg::NUM_SETS-1:0] mru;
   logic                             victim;
   logic                             victim_nxt;
   logic                             victim_dirty;
   logic [1:0]                       victim_oh;
   logic [mem_sys_pkg::STEP_W-1:0]   step;
   logic [mem_sys_pkg::STEP_W-1:0]   ret_step;
   logic                             fill_ret;
   logic                             hit_q;
   logic                             err_q;
   logic                             wr_q;

   assign index      = addr[mem_sys_pkg::OFF_W+1 +: mem_sys_pkg::INDEX_W];
   assign req_offset = addr[1 +: mem_sys_pkg::OFF_W];
   assign bad_req    = (rd && wr) || addr[0];

   // Invalid way first, way 0 before way 1, else the least recently used
   always_comb begin
      if (!way_valid[0]) begin
         victim_nxt = 1'b0;
      end else if (!way_valid[1]) begin
         victim_nxt = 1'b1;
      end else begin
         victim_nxt = !mru[index];
      end
      victim_dirty = way_valid[victim_nxt] && way_dirty[victim_nxt];
   end

   assign victim_oh = victim ? 2'b10 : 2'b01;

   // Word k of the fill lands MEM_LAT+1 steps after its issue step
   assign ret_step = step - mem_sys_pkg::STEP_RET_START;
   assign fill_ret = (step >= mem_sys_pkg::STEP_RET_START);

   always_comb begin
      state_nxt = state;
      case (state)
         mem_sys_pkg::ST_IDLE: begin
            if (rd || wr) begin
               state_nxt = bad_req ? mem_sys_pkg::ST_FINISH : mem_sys_pkg::ST_COMPARE;
            end
         end
         mem_sys_pkg::ST_COMPARE: begin
            if (|way_hit) begin
               state_nxt = mem_sys_pkg::ST_FINISH;
            end else if (victim_dirty) begin
               state_nxt = mem_sys_pkg::ST_WB;
            end else begin
               state_nxt = mem_sys_pkg::ST_FILL;
            end
         end
         mem_sys_pkg::ST_WB: begin
            if (step == mem_sys_pkg::STEP_ISSUE_END) state_nxt = mem_sys_pkg::ST_FILL;
         end
         mem_sys_pkg::ST_FILL: begin
            if (step == mem_sys_pkg::STEP_ISSUE_END) state_nxt = mem_sys_pkg::ST_FILL_WAIT;
         end
         mem_sys_pkg::ST_FILL_WAIT: begin
            if (step == mem_sys_pkg::STEP_WAIT_END) state_nxt = mem_sys_pkg::ST_RECOMP;
         end
         mem_sys_pkg::ST_RECOMP: state_nxt = mem_sys_pkg::ST_FINISH;
         default: state_nxt = mem_sys_pkg::ST_IDLE;
      endcase
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state  <= mem_sys_pkg::ST_IDLE;
         step   <= '0;
         victim <= 1'b0;
         hit_q  <= 1'b0;
         err_q  <= 1'b0;
         wr_q   <= 1'b0;
         mru    <= '0;
      end else begin
         state <= state_nxt;
         if (state_nxt != state && (state_nxt == mem_sys_pkg::ST_WB ||
                                    state_nxt == mem_sys_pkg::ST_FILL)) begin
            step <= '0;
         end else begin
            step <= step + 1'b1;
         end
         case (state)
            mem_sys_pkg::ST_IDLE: begin
               err_q <= bad_req;
               wr_q  <= wr;
            end
            mem_sys_pkg::ST_COMPARE: begin
               hit_q  <= |way_hit;
               victim <= victim_nxt;
            end
            // Completed access makes its way the most recent
            mem_sys_pkg::ST_FINISH: begin
               if (!err_q) mru[index] <= way_hit[1];
            end
            default: ;
         endcase
      end
   end

   always_comb begin
      way_en     = 2'b00;
      way_offset = req_offset;
      way_comp   = 1'b0;
      way_write  = 1'b0;
      fill_src   = 1'b1;
      tag_src    = 1'b1;
      mem_rd     = 1'b0;
      mem_wr     = 1'b0;
      mem_offset = step[mem_sys_pkg::OFF_W-1:0];
      case (state)
         mem_sys_pkg::ST_COMPARE: begin
            way_en   = 2'b11;
            way_comp = 1'b1;
         end
         mem_sys_pkg::ST_WB: begin
            way_en     = victim_oh;
            way_offset = step[mem_sys_pkg::OFF_W-1:0];
            tag_src    = 1'b0;
            mem_wr     = 1'b1;
         end
         mem_sys_pkg::ST_FILL, mem_sys_pkg::ST_FILL_WAIT, mem_sys_pkg::ST_RECOMP: begin
            way_en   = victim_oh;
            fill_src = 1'b0;
            mem_rd   = (state == mem_sys_pkg::ST_FILL);
            if (fill_ret) begin
               way_write  = 1'b1;
               way_offset = ret_step[mem_sys_pkg::OFF_W-1:0];
            end
         end
         // Writes land here, hit or refilled
         mem_sys_pkg::ST_FINISH: begin
            way_en    = 2'b11;
            way_comp  = 1'b1;
            way_write = wr_q && !err_q;
         end
         default: ;
      endcase
   end

   assign done      = (state == mem_sys_pkg::ST_FINISH);
   assign stall     = (state != mem_sys_pkg::ST_IDLE);
   assign cache_hit = done && hit_q && !err_q;
   assign err       = done && err_q;

endmodule

//--- hdl/cache_way.sv
`timescale 1ns/1ps
// One cache way: valid, dirty, tag and a four-word line per set
// Combinational lookup, compare-mode and fill-mode writes
module cache_way (
   input  logic                            clk,
   input  logic                            rst_n,
   input  logic                            en,
   input  logic                            comp,
   input  logic                            write,
   input  logic [mem_sys_pkg::TAG_W-1:0]   tag_in,
   input  logic [mem_sys_pkg::INDEX_W-1:0] index,
   input  logic [mem_sys_pkg::OFF_W-1:0]   offset,
   input  logic [mem_sys_pkg::DATA_W-1:0]  wdata,
   output logic [mem_sys_pkg::DATA_W-1:0]  rdata,
   output logic [mem_sys_pkg::TAG_W-1:0]   tag_out,
   output logic                            hit,
   output logic                            valid,
   output logic                            dirty
);

   logic [mem_sys_pkg::DATA_W-1:0] data_mem [mem_sys_pkg::NUM_SETS][mem_sys_pkg::LINE_WORDS];
   logic [mem_sys_pkg::TAG_W-1:0]  tag_mem  [mem_sys_pkg::NUM_SETS];
   logic [mem_sys_pkg::NUM_SETS-1:0] valid_q;
   logic [mem_sys_pkg::NUM_SETS-1:0] dirty_q;

   logic comp_wr;
   logic fill_wr;

   assign rdata   = data_mem[index][offset];
   assign tag_out = tag_mem[index];
   assign valid   = valid_q[index];
   assign dirty   = dirty_q[index];
   assign hit     = valid_q[index] && (tag_mem[index] == tag_in);

   // Compare mode only touches the line on a hit
   assign comp_wr = en && write && comp && hit;
   assign fill_wr = en && write && !comp;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         valid_q <= '0;
         dirty_q <= '0;
      end else if (fill_wr) begin
         valid_q[index] <= 1'b1;
         dirty_q[index] <= 1'b0;
      end else if (comp_wr) begin
         dirty_q[index] <= 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (comp_wr || fill_wr) begin
         data_mem[index][offset] <= wdata;
      end
      if (fill_wr) begin
         tag_mem[index] <= tag_in;
      end
   end

endmodule

//--- hdl/mem_sys_pkg.sv
// Address fields, line geometry and memory latency for the cache system
// Controller state encoding
package mem_sys_pkg;

   localparam int ADDR_W     = 16;
   localparam int DATA_W     = 16;
   localparam int TAG_W      = 5;
   localparam int INDEX_W    = 8;
   localparam int OFF_W      = 2;
   localparam int LINE_WORDS = 4;
   localparam int MEM_LAT    = 2;

   localparam int NUM_SETS  = 1 << INDEX_W;
   localparam int MEM_WORDS = 32768;
   localparam int BANK_ROWS = MEM_WORDS / LINE_WORDS;
   localparam int ROW_W     = $clog2(BANK_ROWS);

   // Step counter covering write-back, fill issue and the fill returns
   localparam int STEP_W = $clog2(LINE_WORDS + MEM_LAT + 1);
   localparam logic [STEP_W-1:0] STEP_ISSUE_END = STEP_W'(LINE_WORDS - 1);
   localparam logic [STEP_W-1:0] STEP_WAIT_END  = STEP_W'(LINE_WORDS - 1 + MEM_LAT);
   localparam logic [STEP_W-1:0] STEP_RET_START = STEP_W'(MEM_LAT + 1);

   typedef enum logic [2:0] {
      ST_IDLE,
      ST_COMPARE,
      ST_WB,
      ST_FILL,
      ST_FILL_WAIT,
      ST_RECOMP,
      ST_FINISH
   } ctrl_state_t;

endpackage
